// File: fdd_cfg_pkg.sv
package fdd_cfg_pkg;

    // kept low so a simulated revolution stays short
    localparam int SYS_CLK_HZ = 4_000_000;

    localparam int MS_DIV     = SYS_CLK_HZ / 1000;
    localparam int RPM300_DIV = SYS_CLK_HZ / 5;      // 300 rpm, 5 rev/s
    localparam int RPM360_DIV = SYS_CLK_HZ / 6;      // 360 rpm, 6 rev/s

    // half bit cells, two per bit
    localparam int CELL_DIV_250  = SYS_CLK_HZ / (2 * 250_000);
    localparam int CELL_DIV_500  = SYS_CLK_HZ / (2 * 500_000);
    localparam int CELL_DIV_1000 = SYS_CLK_HZ / (2 * 1_000_000);

    localparam int SPINUP_MS  = 3;
    localparam int SETTLE_MS  = 3;
    localparam int MAX_TRACKS = 80;
    localparam int NUM_UNITS  = 4;

    localparam logic [7:0] GAP_BYTE = 8'h4E;

    typedef enum logic [1:0] {DENS_250, DENS_500, DENS_1000} density_e;
    typedef enum logic [1:0] {SZ_128, SZ_256, SZ_512, SZ_1024} sec_size_e;

    typedef struct packed {
        density_e   density;
        sec_size_e  sec_size;
        logic [5:0] sectors;   // sectors per track
        logic       mfm;       // 0 FM, 1 MFM
        logic       rpm360;    // 0 300 rpm, 1 360 rpm
    } fdd_geom_t;

    typedef enum logic [2:0] {CS_IDLE, CS_SPINUP, CS_SETTLE, CS_LOAD, CS_STREAM} ctrl_state_e;

    // raw sector bytes on one track, 63 x 1024 still fits
    function automatic logic [15:0] track_bytes(input fdd_geom_t g);
        return 16'({10'd0, g.sectors} << (7 + g.sec_size));
    endfunction

endpackage

// File: fdd_bus_pkg.sv
package fdd_bus_pkg;

    // shugart bus, all lines active low except usel
    typedef struct packed {
        logic [1:0] usel;
        logic       motor_n;
        logic       step_n;
        logic       sdir_n;    // low steps inward
        logic       side_n;
    } fdd_bus_in_t;

    typedef struct packed {
        logic ready_n;
        logic wprot_n;
        logic track0_n;
        logic index_n;
        logic read_data_n;
    } fdd_bus_out_t;

    typedef struct packed {
        logic [1:0] unit;
        logic [6:0] track;
        logic       side;
    } fdd_pos_t;

    typedef struct packed {
        logic [31:0] lba;
        logic [5:0]  blk_cnt;
    } sd_req_t;

endpackage

// File: fdd_tick_gen.sv
`timescale 1ns/1ns

module fdd_tick_gen import fdd_cfg_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  fdd_geom_t geom_sel,
    output logic      ms_tick,
    output logic      rot_tick,
    output logic      cell_tick
);

    logic [19:0] cnt [6];
    logic [5:0]  tick;

    // 0 ms, 1 rpm300, 2 rpm360, 3..5 half cells for 250/500/1000k
    function automatic logic [19:0] div_of(input int idx);
        case (idx)
            0:       return 20'(MS_DIV);
            1:       return 20'(RPM300_DIV);
            2:       return 20'(RPM360_DIV);
            3:       return 20'(CELL_DIV_250);
            4:       return 20'(CELL_DIV_500);
            default: return 20'(CELL_DIV_1000);
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 6; i++) begin
                cnt[i] <= '0;
            end
            tick <= '0;
        end else begin
            for (int i = 0; i < 6; i++) begin
                if (cnt[i] == div_of(i) - 20'd1) begin
                    cnt[i]  <= '0;
                    tick[i] <= 1'b1;      // one cycle strobe
                end else begin
                    cnt[i]  <= cnt[i] + 20'd1;
                    tick[i] <= 1'b0;
                end
            end
        end
    end

    assign ms_tick  = tick[0];
    assign rot_tick = geom_sel.rpm360 ? tick[2] : tick[1];

    always_comb begin
        case (geom_sel.density)
            DENS_500:  cell_tick = tick[4];
            DENS_1000: cell_tick = tick[5];
            default:   cell_tick = tick[3];
        endcase
    end

endmodule

// File: fdd_drive_ctrl.sv
`timescale 1ns/1ns

module fdd_drive_ctrl import fdd_cfg_pkg::*, fdd_bus_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  fdd_bus_in_t bus_in,
    input  fdd_geom_t   geom [NUM_UNITS],
    input  logic [3:0]  img_mounted,
    input  logic [3:0]  img_readonly,
    input  logic        ms_tick,
    input  logic        load_done,
    output logic        ready_n,
    output logic        wprot_n,
    output logic        track0_n,
    output fdd_geom_t   cur_geom,
    output logic        load_req,
    output fdd_pos_t    load_pos,
    output logic        stream_en
);

    ctrl_state_e state;
    logic [6:0]  head_trk [NUM_UNITS];   // one head per unit
    logic [1:0]  usel_q;
    logic        step_q;
    logic        side_q;
    logic [3:0]  spin_cnt;
    logic [3:0]  settle_cnt;
    fdd_pos_t    loaded_pos;
    logic        loaded_vld;
    fdd_pos_t    cur_pos;
    logic        step_fall;
    logic        side_chg;
    logic        unit_chg;
    logic        spin_ok;

    assign unit_chg  = bus_in.usel != usel_q;
    assign step_fall = step_q & ~bus_in.step_n;
    assign side_chg  = bus_in.side_n != side_q;
    assign spin_ok   = ~bus_in.motor_n & img_mounted[bus_in.usel];
    assign cur_geom  = geom[bus_in.usel];
    assign cur_pos   = '{unit: bus_in.usel, track: head_trk[bus_in.usel], side: ~bus_in.side_n};

    // head stepping, clamped to the track range
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int u = 0; u < NUM_UNITS; u++) begin
                head_trk[u] <= '0;
            end
        end else if (step_fall) begin
            if (!bus_in.sdir_n) begin
                if (head_trk[bus_in.usel] != 7'(MAX_TRACKS - 1))
                    head_trk[bus_in.usel] <= head_trk[bus_in.usel] + 7'd1;
            end else if (head_trk[bus_in.usel] != '0) begin
                head_trk[bus_in.usel] <= head_trk[bus_in.usel] - 7'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= CS_IDLE;
            usel_q     <= '0;
            step_q     <= 1'b1;
            side_q     <= 1'b1;
            spin_cnt   <= '0;
            settle_cnt <= '0;
            loaded_pos <= '0;
            loaded_vld <= 1'b0;
            ready_n    <= 1'b1;
            wprot_n    <= 1'b1;
            track0_n   <= 1'b1;
            load_req   <= 1'b0;
            load_pos   <= '0;
            stream_en  <= 1'b0;
        end else begin
            usel_q   <= bus_in.usel;
            step_q   <= bus_in.step_n;
            side_q   <= bus_in.side_n;
            wprot_n  <= ~(img_mounted[bus_in.usel] & img_readonly[bus_in.usel]);
            track0_n <= head_trk[bus_in.usel] != '0;
            load_req <= 1'b0;
            if (!spin_ok || unit_chg) begin
                state     <= CS_IDLE;     // motor off or other unit
                ready_n   <= 1'b1;
                stream_en <= 1'b0;
            end else begin
                case (state)
                    CS_IDLE: begin
                        state    <= CS_SPINUP;
                        spin_cnt <= '0;
                    end
                    CS_SPINUP: begin
                        if (ms_tick) begin
                            if (spin_cnt == 4'(SPINUP_MS - 1)) begin
                                ready_n    <= 1'b0;
                                state      <= CS_SETTLE;
                                settle_cnt <= '0;
                            end else begin
                                spin_cnt <= spin_cnt + 4'd1;
                            end
                        end
                    end
                    CS_SETTLE: begin
                        // any step or side change restarts the settle time
                        if (step_fall || side_chg) begin
                            settle_cnt <= '0;
                        end else if (ms_tick) begin
                            if (settle_cnt == 4'(SETTLE_MS - 1)) begin
                                if (!loaded_vld || cur_pos != loaded_pos) begin
                                    load_req <= 1'b1;
                                    load_pos <= cur_pos;
                                    state    <= CS_LOAD;
                                end else begin
                                    state <= CS_STREAM;
                                end
                            end else begin
                                settle_cnt <= settle_cnt + 4'd1;
                            end
                        end
                    end
                    CS_LOAD: begin
                        if (load_done) begin
                            loaded_pos <= load_pos;
                            loaded_vld <= 1'b1;
                            stream_en  <= 1'b1;
                            state      <= CS_SETTLE;   // recheck, head may have moved
                            settle_cnt <= '0;
                        end
                    end
                    CS_STREAM: begin
                        if (step_fall || side_chg) begin
                            state      <= CS_SETTLE;
                            settle_cnt <= '0;
                        end
                    end
                    default: state <= CS_IDLE;
                endcase
            end
        end
    end

endmodule

// File: fdd_track_loader.sv
`timescale 1ns/1ns

module fdd_track_loader import fdd_cfg_pkg::*, fdd_bus_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        load_req,
    input  fdd_pos_t    load_pos,
    input  fdd_geom_t   cur_geom,
    output sd_req_t     sd_req,
    output logic        sd_rd,
    input  logic        sd_ack,
    input  logic [12:0] sd_buff_addr,
    input  logic [7:0]  sd_buff_dout,
    input  logic        sd_buff_wr,
    output logic        wr_en,
    output logic [12:0] wr_addr,
    output logic [7:0]  wr_data,
    output logic        load_done
);

    fdd_pos_t    pend_pos;
    logic        pend;
    logic        busy;
    logic        ack_q;
    logic [5:0]  bpt;        // 512 byte blocks per track
    logic [31:0] lba;

    assign bpt = 6'((17'(track_bytes(cur_geom)) + 17'd511) >> 9);

    // image laid out unit by unit, then track, then side
    assign lba = ((32'(pend_pos.unit) * MAX_TRACKS + 32'(pend_pos.track)) * 2
                  + 32'(pend_pos.side)) * 32'(bpt);

    always_ff @(posedge clk) begin
        if (reset) begin
            pend      <= 1'b0;
            pend_pos  <= '0;
            busy      <= 1'b0;
            ack_q     <= 1'b0;
            sd_rd     <= 1'b0;
            sd_req    <= '0;
            load_done <= 1'b0;
        end else begin
            ack_q     <= sd_ack;
            load_done <= 1'b0;
            if (load_req)
                pend_pos <= load_pos;
            if (!busy && pend) begin
                sd_req <= '{lba: lba, blk_cnt: bpt};
                sd_rd  <= 1'b1;
                busy   <= 1'b1;
                pend   <= load_req;      // keep a request that lands now
            end else if (load_req) begin
                pend <= 1'b1;
            end
            if (sd_rd && sd_ack)
                sd_rd <= 1'b0;           // host has taken the request
            if (busy && ack_q && !sd_ack) begin
                busy      <= 1'b0;
                load_done <= 1'b1;
            end
        end
    end

    assign wr_en   = busy & sd_ack & sd_buff_wr;
    assign wr_addr = sd_buff_addr;
    assign wr_data = sd_buff_dout;

endmodule

// File: fdd_track_buffer.sv
`timescale 1ns/1ns

module fdd_track_buffer (
    input  logic        clk,
    input  logic        wr_en,
    input  logic [12:0] wr_addr,
    input  logic [7:0]  wr_data,
    input  logic [12:0] rd_addr,
    output logic [7:0]  rd_data
);

    logic [7:0] mem [8192];   // one full track, up to 8 KB

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    // registered read for the encoder prefetch
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: fdd_flux_encoder.sv
`timescale 1ns/1ns

module fdd_flux_encoder import fdd_cfg_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        stream_en,
    input  logic        rot_tick,
    input  logic        cell_tick,
    input  fdd_geom_t   cur_geom,
    output logic [12:0] rd_addr,
    input  logic [7:0]  rd_data,
    output logic        index_n,
    output logic        read_data_n
);

    logic [15:0] tbytes;
    logic [15:0] nxt_idx;      // byte waiting in the prefetch
    logic [7:0]  nxt_data;
    logic [7:0]  sr;
    logic [2:0]  bit_cnt;
    logic [1:0]  start_wait;
    logic        starting;
    logic        sending;
    logic        half;         // 0 clock half-cell, 1 data half-cell
    logic        prev_bit;
    logic        pulse;

    assign tbytes   = track_bytes(cur_geom);
    assign nxt_data = (nxt_idx < tbytes) ? rd_data : GAP_BYTE;
    assign rd_addr  = nxt_idx[12:0];

    // FM clocks every bit, MFM only between two zeros
    assign pulse = half ? sr[7] : (~cur_geom.mfm | (~prev_bit & ~sr[7]));

    always_ff @(posedge clk) begin
        if (reset) begin
            nxt_idx     <= '0;
            sr          <= '0;
            bit_cnt     <= '0;
            start_wait  <= '0;
            starting    <= 1'b0;
            sending     <= 1'b0;
            half        <= 1'b0;
            prev_bit    <= 1'b0;
            index_n     <= 1'b1;
            read_data_n <= 1'b1;
        end else begin
            read_data_n <= 1'b1;
            if (!stream_en) begin
                starting <= 1'b0;
                sending  <= 1'b0;
                index_n  <= 1'b1;
            end else if (rot_tick) begin
                nxt_idx    <= '0;         // new revolution, back to byte 0
                start_wait <= 2'd2;       // let the RAM read settle
                starting   <= 1'b1;
                sending    <= 1'b0;
                index_n    <= 1'b1;
            end else if (starting) begin
                if (start_wait != '0) begin
                    start_wait <= start_wait - 2'd1;
                end else if (cell_tick) begin
                    sr       <= nxt_data;
                    bit_cnt  <= '0;
                    half     <= 1'b0;
                    sending  <= 1'b1;
                    starting <= 1'b0;
                    index_n  <= 1'b0;     // low for all of byte 0
                    if (nxt_idx < tbytes)
                        nxt_idx <= nxt_idx + 16'd1;
                end
            end else if (sending && cell_tick) begin
                read_data_n <= ~pulse;
                if (!half) begin
                    half <= 1'b1;
                end else begin
                    half     <= 1'b0;
                    prev_bit <= sr[7];
                    if (bit_cnt == 3'd7) begin
                        sr      <= nxt_data;   // no bubble between bytes
                        bit_cnt <= '0;
                        index_n <= 1'b1;
                        if (nxt_idx < tbytes)
                            nxt_idx <= nxt_idx + 16'd1;
                    end else begin
                        sr      <= {sr[6:0], 1'b0};
                        bit_cnt <= bit_cnt + 3'd1;
                    end
                end
            end
        end
    end

endmodule

// File: fdd_top.sv
`timescale 1ns/1ns

module fdd_top import fdd_cfg_pkg::*, fdd_bus_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  fdd_bus_in_t  bus_in,
    input  fdd_geom_t    geom [NUM_UNITS],
    input  logic [3:0]   img_mounted,
    input  logic [3:0]   img_readonly,
    output sd_req_t      sd_req,
    output logic         sd_rd,
    input  logic         sd_ack,
    input  logic [12:0]  sd_buff_addr,
    input  logic [7:0]   sd_buff_dout,
    input  logic         sd_buff_wr,
    output fdd_bus_out_t bus_out
);

    logic        ms_tick;
    logic        rot_tick;
    logic        cell_tick;
    logic        ready_n;
    logic        wprot_n;
    logic        track0_n;
    logic        index_n;
    logic        read_data_n;
    fdd_geom_t   cur_geom;      // geometry of the selected unit
    logic        load_req;
    fdd_pos_t    load_pos;
    logic        load_done;
    logic        stream_en;
    logic        wr_en;
    logic [12:0] wr_addr;
    logic [7:0]  wr_data;
    logic [12:0] rd_addr;
    logic [7:0]  rd_data;

    fdd_tick_gen u_tick_gen (
        .clk(clk), .reset(reset), .geom_sel(cur_geom),
        .ms_tick(ms_tick), .rot_tick(rot_tick), .cell_tick(cell_tick)
    );

    fdd_drive_ctrl u_drive_ctrl (
        .clk(clk), .reset(reset), .bus_in(bus_in), .geom(geom),
        .img_mounted(img_mounted), .img_readonly(img_readonly),
        .ms_tick(ms_tick), .load_done(load_done),
        .ready_n(ready_n), .wprot_n(wprot_n), .track0_n(track0_n),
        .cur_geom(cur_geom), .load_req(load_req), .load_pos(load_pos),
        .stream_en(stream_en)
    );

    fdd_track_loader u_track_loader (
        .clk(clk), .reset(reset), .load_req(load_req), .load_pos(load_pos),
        .cur_geom(cur_geom), .sd_req(sd_req), .sd_rd(sd_rd), .sd_ack(sd_ack),
        .sd_buff_addr(sd_buff_addr), .sd_buff_dout(sd_buff_dout),
        .sd_buff_wr(sd_buff_wr), .wr_en(wr_en), .wr_addr(wr_addr),
        .wr_data(wr_data), .load_done(load_done)
    );

    fdd_track_buffer u_track_buffer (
        .clk(clk), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_addr(rd_addr), .rd_data(rd_data)
    );

    fdd_flux_encoder u_flux_encoder (
        .clk(clk), .reset(reset), .stream_en(stream_en), .rot_tick(rot_tick),
        .cell_tick(cell_tick), .cur_geom(cur_geom), .rd_addr(rd_addr),
        .rd_data(rd_data), .index_n(index_n), .read_data_n(read_data_n)
    );

    assign bus_out = '{ready_n: ready_n, wprot_n: wprot_n, track0_n: track0_n,
                       index_n: index_n, read_data_n: read_data_n};

endmodule

// File: fdd_tb_sd_model.sv
`timescale 1ns/1ns

module fdd_tb_sd_model import fdd_bus_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  sd_req_t     sd_req,
    input  logic        sd_rd,
    output logic        sd_ack,
    output logic [12:0] sd_buff_addr,
    output logic [7:0]  sd_buff_dout,
    output logic        sd_buff_wr
);

    sd_req_t     req;
    logic [31:0] blk_lba;

    // one request at a time, one byte per clock while ack is high
    initial begin
        sd_ack       = 1'b0;
        sd_buff_addr = '0;
        sd_buff_dout = '0;
        sd_buff_wr   = 1'b0;
        forever begin
            @(posedge clk);
            if (!reset && sd_rd) begin
                req = sd_req;            // held stable by the loader
                @(posedge clk);
                sd_ack <= 1'b1;
                for (int b = 0; b < int'(req.blk_cnt); b++) begin
                    blk_lba = req.lba + 32'(b);
                    for (int i = 0; i < 512; i++) begin
                        @(posedge clk);
                        sd_buff_addr <= 13'(b * 512 + i);
                        sd_buff_dout <= 8'(blk_lba * 32'd7 + 32'(i)); // image byte rule
                        sd_buff_wr   <= 1'b1;
                    end
                end
                @(posedge clk);
                sd_buff_wr <= 1'b0;
                @(posedge clk);
                sd_ack <= 1'b0;          // end of transfer
            end
        end
    end

endmodule

// File: fdd_tb.sv
`timescale 1ns/1ns

module fdd_tb import fdd_cfg_pkg::*, fdd_bus_pkg::*;;

    localparam int MS_CYC          = 4000;       // 1 ms at 4 MHz
    localparam int REV_CYC         = 800_000;    // one turn at 300 rpm
    localparam int HALF_CELL       = 8;          // 250 kbit/s
    localparam int BYTE_CYC        = 16 * HALF_CELL;
    localparam int SPIN_DELAY_MS   = 3;
    localparam int SETTLE_DELAY_MS = 3;
    localparam int TRACK_CNT       = 80;
    localparam int SEC_LEN         = 128;
    localparam int SEC_CNT         = 1;
    localparam int BLK_PER_TRK     = (SEC_LEN * SEC_CNT + 511) / 512;
    localparam int N_BYTES         = 16;         // bytes decoded per stream test
    localparam int N_CELLS         = N_BYTES * 16;
    localparam int SIG_READY       = 0;
    localparam int SIG_INDEX       = 1;
    localparam int SIG_SD_RD       = 2;
    localparam int SIG_SD_ACK      = 3;

    logic         clk;
    logic         reset;
    fdd_bus_in_t  bus_in;
    fdd_geom_t    geom [NUM_UNITS];
    logic [3:0]   img_mounted;
    logic [3:0]   img_readonly;
    sd_req_t      sd_req;
    logic         sd_rd;
    logic         sd_ack;
    logic [12:0]  sd_buff_addr;
    logic [7:0]   sd_buff_dout;
    logic         sd_buff_wr;
    fdd_bus_out_t bus_out;

    int          err_cnt;
    int          test_cnt;
    int          test_fail_cnt;
    int          test_err_base;
    int          exp_trk;           // expected head track of unit 1
    logic [31:0] lba_side0;
    logic        cell_hit [N_CELLS];  // pulse seen in half-cell slot
    int unsigned seed;

    fdd_top u_fdd_top (
        .clk(clk), .reset(reset), .bus_in(bus_in), .geom(geom),
        .img_mounted(img_mounted), .img_readonly(img_readonly),
        .sd_req(sd_req), .sd_rd(sd_rd), .sd_ack(sd_ack),
        .sd_buff_addr(sd_buff_addr), .sd_buff_dout(sd_buff_dout),
        .sd_buff_wr(sd_buff_wr), .bus_out(bus_out)
    );

    fdd_tb_sd_model u_sd_model (
        .clk(clk), .reset(reset), .sd_req(sd_req), .sd_rd(sd_rd), .sd_ack(sd_ack),
        .sd_buff_addr(sd_buff_addr), .sd_buff_dout(sd_buff_dout), .sd_buff_wr(sd_buff_wr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // track offset within the unit, plus the unit's whole image region
    function automatic logic [31:0] expect_lba(input int unit, input int trk, input int side);
        return 32'((trk * 2 + side) * BLK_PER_TRK + unit * TRACK_CNT * 2 * BLK_PER_TRK);
    endfunction

    function automatic logic [7:0] pattern_byte(input logic [31:0] lba, input int i);
        return 8'(lba * 32'd7 + 32'(i));
    endfunction

    function automatic logic probe(input int id);
        case (id)
            SIG_READY: return bus_out.ready_n;
            SIG_INDEX: return bus_out.index_n;
            SIG_SD_RD: return sd_rd;
            default:   return sd_ack;
        endcase
    endfunction

    task record_fail(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        err_cnt++;
    endtask

    task finish_test(input string name);
        test_cnt++;
        if (err_cnt == test_err_base) begin
            $display("%s: ok", name);
        end else begin
            test_fail_cnt++;
            $display("%s: %0d errors", name, err_cnt - test_err_base);
        end
    endtask

    // cycles waited, or -1 on timeout
    task wait_level(input int id, input logic level, input int max_cyc,
                    input string what, output int cycles);
        cycles = 0;
        while (probe(id) !== level && cycles < max_cyc) begin
            @(negedge clk);
            cycles++;
        end
        if (probe(id) !== level) begin
            $display("timeout while waiting for %s", what);
            err_cnt++;
            cycles = -1;
        end
    endtask

    task await_load;
        int n;
        wait_level(SIG_SD_ACK, 1'b1, 8, "sd_ack to rise", n);
        wait_level(SIG_SD_ACK, 1'b0, BLK_PER_TRK * 512 + 16, "sd_ack to fall", n);
    endtask

    // returns on the first sample with index_n low, a fresh revolution
    task await_index(output bit ok);
        int n;
        wait_level(SIG_INDEX, 1'b1, 2 * BYTE_CYC, "index_n to rise", n);
        ok = n >= 0;
        if (ok) begin
            wait_level(SIG_INDEX, 1'b0, 2 * REV_CYC, "index_n to fall", n);
            ok = n >= 0;
        end
    endtask

    task step_head(input logic outward);
        @(posedge clk);
        bus_in.sdir_n <= outward;
        bus_in.step_n <= 1'b0;
        @(posedge clk);
        bus_in.step_n <= 1'b1;
        if (!outward && exp_trk < TRACK_CNT - 1)
            exp_trk++;
        else if (outward && exp_trk > 0)
            exp_trk--;
        @(posedge clk);
        @(negedge clk);
        assert (bus_out.track0_n == (exp_trk != 0))
        else record_fail($sformatf("track0_n %b at track %0d", bus_out.track0_n, exp_trk));
    endtask

    // slot k sits (k+1) half-cells after the index fall
    task capture_flux(input bit mfm);
        int cyc;
        int last;
        int low_cnt;
        int slot;
        for (int k = 0; k < N_CELLS; k++)
            cell_hit[k] = 1'b0;
        cyc     = 0;
        last    = -1000;
        low_cnt = 1;
        while (cyc < N_CELLS * HALF_CELL) begin
            @(negedge clk);
            cyc++;
            if (!bus_out.index_n)
                low_cnt++;
            if (!bus_out.read_data_n) begin
                slot = cyc / HALF_CELL - 1;
                assert (cyc % HALF_CELL == 0)
                else record_fail($sformatf("pulse off the cell grid at %0d", cyc));
                if (mfm)
                    assert (cyc - last >= 2 * HALF_CELL)
                    else record_fail($sformatf("MFM pulses %0d cycles apart", cyc - last));
                if (slot < N_CELLS)
                    cell_hit[slot] = 1'b1;
                last = cyc;
            end
        end
        assert (low_cnt == BYTE_CYC)
        else record_fail($sformatf("index_n low for %0d cycles", low_cnt));
    endtask

    task check_bytes(input bit mfm, input logic [31:0] lba);
        logic [7:0] got;
        logic [7:0] exp;
        logic       prev;
        logic       clk_exp;
        int         s;
        prev = 1'b0;
        for (int b = 0; b < N_BYTES; b++) begin
            got = '0;
            for (int j = 0; j < 8; j++) begin
                s       = (b * 8 + j) * 2;
                got     = {got[6:0], cell_hit[s + 1]};    // msb first
                clk_exp = mfm ? (!prev && !cell_hit[s + 1]) : 1'b1;
                if (s != 0 || !mfm)                        // mfm first clock hangs on the gap
                    assert (cell_hit[s] == clk_exp)
                    else record_fail($sformatf("clock cell wrong, byte %0d bit %0d", b, j));
                prev = cell_hit[s + 1];
            end
            exp = pattern_byte(lba, b);
            assert (got == exp)
            else record_fail($sformatf("byte %0d is %02h, expected %02h", b, got, exp));
        end
    endtask

    task reset_state_test;
        test_err_base = err_cnt;
        @(negedge clk);
        assert (bus_out == 5'b11111)
        else record_fail($sformatf("bus_out %b in reset", bus_out));
        assert (sd_rd == 1'b0) else record_fail("sd_rd high in reset");
        finish_test("reset state");
    endtask

    task motor_ready_test;
        int n;
        test_err_base = err_cnt;
        @(posedge clk);
        bus_in.usel    <= 2'd1;
        bus_in.motor_n <= 1'b0;
        wait_level(SIG_READY, 1'b0, (SPIN_DELAY_MS + 1) * MS_CYC, "ready_n to fall", n);
        if (n >= 0) begin
            assert (n >= (SPIN_DELAY_MS - 1) * MS_CYC && n <= SPIN_DELAY_MS * MS_CYC + 4)
            else record_fail($sformatf("ready_n fell after %0d cycles", n));
            assert (bus_out.wprot_n == 1'b0) else record_fail("wprot_n high on read-only unit");
        end
        @(posedge clk);
        bus_in.motor_n <= 1'b1;
        repeat (2) @(negedge clk);
        assert (bus_out.ready_n == 1'b1) else record_fail("ready_n low after motor off");
        finish_test("motor and ready");
    endtask

    task stepping_test;
        int n_in;
        int n_fin;
        test_err_base = err_cnt;
        n_in = 1 + int'($urandom % 30);
        repeat (n_in) step_head(1'b0);
        repeat (n_in + 2) step_head(1'b1);    // runs into the track 0 stop
        n_fin = 1 + int'($urandom % 20);
        repeat (n_fin) step_head(1'b0);
        finish_test("stepping");
    endtask

    task load_request_test;
        int n;
        test_err_base = err_cnt;
        lba_side0 = expect_lba(1, exp_trk, 0);
        @(posedge clk);
        bus_in.motor_n <= 1'b0;
        wait_level(SIG_READY, 1'b0, (SPIN_DELAY_MS + 1) * MS_CYC, "ready_n to fall", n);
        wait_level(SIG_SD_RD, 1'b1, (SETTLE_DELAY_MS + 1) * MS_CYC, "sd_rd to rise", n);
        if (n >= 0) begin
            assert (sd_req.lba == lba_side0)
            else record_fail($sformatf("lba %0d, expected %0d", sd_req.lba, lba_side0));
            assert (sd_req.blk_cnt == 6'(BLK_PER_TRK))
            else record_fail($sformatf("blk_cnt %0d", sd_req.blk_cnt));
        end
        await_load();
        finish_test("load request");
    endtask

    task fm_stream_test;
        bit ok;
        test_err_base = err_cnt;
        await_index(ok);
        if (ok) begin
            capture_flux(1'b0);
            check_bytes(1'b0, lba_side0);
        end
        finish_test("FM stream");
    endtask

    task mfm_stream_test;
        int          n;
        bit          ok;
        logic [31:0] exp_lba;
        test_err_base = err_cnt;
        exp_lba = expect_lba(1, exp_trk, 1);
        @(posedge clk);
        geom[1].mfm   <= 1'b1;
        bus_in.side_n <= 1'b0;                // side 1, forces a reload
        wait_level(SIG_SD_RD, 1'b1, (SETTLE_DELAY_MS + 1) * MS_CYC, "sd_rd to rise", n);
        if (n >= 0)
            assert (sd_req.lba == exp_lba)
            else record_fail($sformatf("lba %0d, expected %0d", sd_req.lba, exp_lba));
        await_load();
        await_index(ok);
        if (ok) begin
            capture_flux(1'b1);
            check_bytes(1'b1, exp_lba);
        end
        finish_test("MFM stream");
    endtask

    initial begin
        seed          = $urandom(32'h5ea);
        err_cnt       = 0;
        test_cnt      = 0;
        test_fail_cnt = 0;
        test_err_base = 0;
        exp_trk       = 0;
        lba_side0     = '0;
        reset         = 1'b1;
        bus_in        = '{usel: 2'd0, motor_n: 1'b1, step_n: 1'b1, sdir_n: 1'b1, side_n: 1'b1};
        for (int u = 0; u < NUM_UNITS; u++)
            geom[u] = '{density: DENS_250, sec_size: SZ_128, sectors: 6'(SEC_CNT),
                        mfm: 1'b0, rpm360: 1'b0};
        img_mounted  = 4'b0010;     // only unit 1, read-only
        img_readonly = 4'b0010;
        repeat (15) @(posedge clk);
        reset_state_test();
        @(posedge clk);
        reset <= 1'b0;
        motor_ready_test();
        stepping_test();
        load_request_test();
        fm_stream_test();
        mfm_stream_test();
        $display("%0d tests run, %0d failed, %0d check errors", test_cnt, test_fail_cnt, err_cnt);
        if (err_cnt == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// File: fdd_top.f
fdd_cfg_pkg.sv
fdd_bus_pkg.sv
fdd_tick_gen.sv
fdd_drive_ctrl.sv
fdd_track_loader.sv
fdd_track_buffer.sv
fdd_flux_encoder.sv
fdd_top.sv
fdd_tb_sd_model.sv
fdd_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns
TOP       = fdd_tb
FILELIST  = fdd_top.f
PASS_MSG  = All tests passed!

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
